// File: src/debug_monitor_pkg.sv
`default_nettype none

package debug_monitor_pkg;

    // --------------------------------------------------
    // uart
    // --------------------------------------------------
    typedef logic [7:0] byte_t;

    localparam int CLKS_PER_BIT = 16;
    typedef logic [$clog2(CLKS_PER_BIT + 1)-1:0] bit_cnt_t;

    // start bit check, pulled in to make up for the two sync flops
    localparam int RX_FIRST_SAMPLE = CLKS_PER_BIT / 2 - 3;

    // --------------------------------------------------
    // cpu clock and reset
    // --------------------------------------------------
    localparam int RESET_HOLD_CYCLES = 16;
    typedef logic [3:0] hold_cnt_t;

    localparam int RUN_DIV_BIT = 10;             // free run period is 2^11 clk
    typedef logic [RUN_DIV_BIT:0] div_cnt_t;

    // --------------------------------------------------
    // command and reply characters
    // --------------------------------------------------
    localparam byte_t CMD_RESET      = 8'h72;    // r
    localparam byte_t CMD_RISE       = 8'h7A;    // z
    localparam byte_t CMD_FALL       = 8'h78;    // x
    localparam byte_t CMD_PULSE      = 8'h63;    // c
    localparam byte_t CMD_RST_TOGGLE = 8'h65;    // e
    localparam byte_t CMD_MANUAL     = 8'h6A;    // j
    localparam byte_t CMD_RUN        = 8'h6B;    // k

    localparam byte_t CHR_CR = 8'h0D;
    localparam byte_t CHR_LF = 8'h0A;

    typedef enum logic [2:0] {
        ST_PWR_HOLD,
        ST_IDLE,
        ST_HOLD_WAIT,
        ST_PULSE_FALL,
        ST_REPLY,
        ST_REPLY_WAIT
    } seq_state_t;

endpackage

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import debug_monitor_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  rx_i,
    output logic  rx_valid_o,
    output byte_t rx_byte_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state;
    bit_cnt_t  cnt;
    logic [2:0] bit_idx;
    logic rx_meta;
    logic rx_sync;

    wire sample = (cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rx_meta    <= 1'b1;                  // idle line level
            rx_sync    <= 1'b1;
            state      <= RX_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_meta    <= rx_i;
            rx_sync    <= rx_meta;
            rx_valid_o <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx_sync) begin
                        cnt   <= bit_cnt_t'(RX_FIRST_SAMPLE);
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (sample) begin
                        cnt     <= bit_cnt_t'(CLKS_PER_BIT - 1);
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;   // glitch, not a start
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        cnt <= bit_cnt_t'(CLKS_PER_BIT - 1);
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    if (sample) begin
                        rx_valid_o <= rx_sync;   // framing error drops the byte
                        state      <= RX_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && sample) begin
            rx_byte_o <= {rx_sync, rx_byte_o[7:1]};
        end
    end

    a_valid_single : assert property (@(posedge clk) disable iff (!rst_n_i)
        rx_valid_o |=> !rx_valid_o);

endmodule

`default_nettype wire

// File: src/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer import debug_monitor_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  rx_valid_i,
    input  byte_t rx_byte_i,
    input  logic  hold_done_i,
    input  logic  reply_done_i,
    output logic  cmd_accept_o,
    output logic  clk_rise_o,
    output logic  clk_fall_o,
    output logic  rst_toggle_o,
    output logic  sel_manual_o,
    output logic  sel_run_o,
    output logic  hold_start_o,
    output logic  reply_start_o
);

    seq_state_t state;
    logic pwr_armed;                             // power-up hold not yet started

    // --------------------------------------------------
    // action pulses, decoded in the accept cycle
    // --------------------------------------------------
    assign cmd_accept_o = (state == ST_IDLE) && rx_valid_i;

    assign clk_rise_o   = cmd_accept_o && (rx_byte_i == CMD_RISE || rx_byte_i == CMD_PULSE);
    assign clk_fall_o   = (cmd_accept_o && rx_byte_i == CMD_FALL) || (state == ST_PULSE_FALL);
    assign rst_toggle_o = cmd_accept_o && (rx_byte_i == CMD_RST_TOGGLE);
    assign sel_manual_o = cmd_accept_o && (rx_byte_i == CMD_MANUAL);
    assign sel_run_o    = cmd_accept_o && (rx_byte_i == CMD_RUN);
    assign hold_start_o = (cmd_accept_o && rx_byte_i == CMD_RESET)
                        || (state == ST_PWR_HOLD && pwr_armed);

    // --------------------------------------------------
    // sequencing
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state         <= ST_PWR_HOLD;
            pwr_armed     <= 1'b1;
            reply_start_o <= 1'b0;
        end else begin
            case (state)
                ST_PWR_HOLD: begin
                    pwr_armed <= 1'b0;
                    if (hold_done_i) begin
                        state <= ST_IDLE;                // silent, no reply
                    end
                end
                ST_IDLE: begin
                    if (rx_valid_i) begin
                        case (rx_byte_i)
                            CMD_RESET: state <= ST_HOLD_WAIT;
                            CMD_PULSE: state <= ST_PULSE_FALL;
                            default:   state <= ST_REPLY;
                        endcase
                    end
                end
                ST_HOLD_WAIT: begin
                    if (hold_done_i) begin
                        state <= ST_REPLY;
                    end
                end
                ST_PULSE_FALL: state <= ST_REPLY;
                ST_REPLY: begin
                    // one quiet cycle so the cpu side settles before the reply
                    if (!reply_start_o) begin
                        reply_start_o <= 1'b1;
                    end else begin
                        reply_start_o <= 1'b0;
                        state         <= ST_REPLY_WAIT;
                    end
                end
                default: begin
                    if (reply_done_i) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    a_reply_in_state : assert property (@(posedge clk) disable iff (!rst_n_i)
        reply_start_o |-> state == ST_REPLY);

endmodule

`default_nettype wire

// File: src/cpu_clock_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_clock_ctrl import debug_monitor_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    input  logic clk_rise_i,
    input  logic clk_fall_i,
    input  logic rst_toggle_i,
    input  logic sel_manual_i,
    input  logic sel_run_i,
    input  logic hold_start_i,
    output logic hold_done_o,
    output logic cpu_clk_o,
    output logic cpu_rst_n_o
);

    logic      man_clk;
    logic      run_sel;                          // 1 = free running divider
    div_cnt_t  div_cnt;
    hold_cnt_t hold_cnt;
    logic      hold_act;

    assign cpu_clk_o = run_sel ? div_cnt[RUN_DIV_BIT] : man_clk;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            man_clk     <= 1'b0;
            run_sel     <= 1'b0;
            div_cnt     <= '0;
            hold_cnt    <= '0;
            hold_act    <= 1'b0;
            hold_done_o <= 1'b0;
            cpu_rst_n_o <= 1'b0;                 // cpu stays in reset with us
        end else begin
            div_cnt     <= div_cnt + 1'b1;
            hold_done_o <= 1'b0;

            // manual clock level
            if (clk_rise_i) begin
                man_clk <= 1'b1;
            end else if (clk_fall_i) begin
                man_clk <= 1'b0;
            end else if (hold_start_i || hold_act) begin
                man_clk <= ~man_clk;             // clock the cpu through reset
            end

            if (sel_manual_i) begin
                run_sel <= 1'b0;
            end else if (sel_run_i) begin
                run_sel <= 1'b1;
            end

            // --------------------------------------------------
            // reset hold, low for RESET_HOLD_CYCLES + 1
            // --------------------------------------------------
            if (hold_start_i) begin
                hold_act    <= 1'b1;
                hold_cnt    <= '0;
                cpu_rst_n_o <= 1'b0;
            end else if (hold_act) begin
                hold_cnt <= hold_cnt + 1'b1;
                if (hold_cnt == hold_cnt_t'(RESET_HOLD_CYCLES - 1)) begin
                    hold_act    <= 1'b0;
                    hold_done_o <= 1'b1;         // release at the next edge
                end
            end else if (hold_done_o) begin
                cpu_rst_n_o <= 1'b1;
            end else if (rst_toggle_i) begin
                cpu_rst_n_o <= ~cpu_rst_n_o;
            end
        end
    end

    a_hold_cnt_in_reset : assert property (@(posedge clk) disable iff (!rst_n_i)
        $changed(hold_cnt) |-> !cpu_rst_n_o);

endmodule

`default_nettype wire

// File: src/reply_sender.sv
`timescale 1ns/1ps
`default_nettype none

module reply_sender import debug_monitor_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  cmd_accept_i,
    input  byte_t rx_byte_i,
    input  logic  reply_start_i,
    input  logic  tx_busy_i,
    output logic  tx_start_o,
    output byte_t tx_byte_o,
    output logic  reply_done_o
);

    byte_t      cmd_q;
    byte_t      next_byte;
    logic [1:0] byte_idx;
    logic       issue_q;                         // next byte due
    logic       wait_q;                          // byte on the line

    // --------------------------------------------------
    // reply table: two letters, then CR LF
    // --------------------------------------------------
    always_comb begin
        next_byte = CHR_LF;
        case (byte_idx)
            2'd0: begin
                case (cmd_q)
                    CMD_RESET, CMD_RST_TOGGLE:     next_byte = "R";
                    CMD_RISE, CMD_FALL, CMD_PULSE: next_byte = "C";
                    CMD_MANUAL, CMD_RUN:           next_byte = "K";
                    default:                       next_byte = "O";
                endcase
            end
            2'd1: begin
                case (cmd_q)
                    CMD_RESET:      next_byte = "s";
                    CMD_RISE:       next_byte = "r";
                    CMD_FALL:       next_byte = "f";
                    CMD_PULSE:      next_byte = "t";
                    CMD_RST_TOGGLE: next_byte = "a";
                    default:        next_byte = "k";   // j, k and unknown
                endcase
            end
            2'd2:    next_byte = CHR_CR;
            default: next_byte = CHR_LF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            byte_idx     <= '0;
            issue_q      <= 1'b0;
            wait_q       <= 1'b0;
            tx_start_o   <= 1'b0;
            reply_done_o <= 1'b0;
        end else begin
            tx_start_o   <= 1'b0;
            reply_done_o <= 1'b0;
            if (reply_start_i) begin
                byte_idx <= '0;
                issue_q  <= 1'b1;
            end else if (issue_q) begin
                tx_start_o <= 1'b1;
                issue_q    <= 1'b0;
                wait_q     <= 1'b1;
            end else if (wait_q && !tx_start_o && !tx_busy_i) begin
                // busy rises a cycle late, hence the tx_start_o check
                wait_q <= 1'b0;
                if (byte_idx == 2'd3) begin
                    reply_done_o <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                    issue_q  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_accept_i) begin
            cmd_q <= rx_byte_i;
        end
        if (issue_q) begin
            tx_byte_o <= next_byte;
        end
    end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import debug_monitor_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  tx_start_i,
    input  byte_t tx_byte_i,
    output logic  tx_o,
    output logic  tx_busy_o
);

    logic [8:0] shift_q;                         // stop bit rides above data
    logic [3:0] bit_idx;                         // 0 start, 1..8 data, 9 stop
    bit_cnt_t   cnt;

    wire bit_end = tx_busy_o && (cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tx_o      <= 1'b1;
            tx_busy_o <= 1'b0;
            cnt       <= '0;
            bit_idx   <= '0;
        end else if (tx_start_i) begin
            tx_o      <= 1'b0;                   // start bit
            tx_busy_o <= 1'b1;
            cnt       <= bit_cnt_t'(CLKS_PER_BIT - 1);
            bit_idx   <= '0;
        end else if (bit_end) begin
            if (bit_idx == 4'd9) begin
                tx_busy_o <= 1'b0;               // end of stop bit
            end else begin
                tx_o    <= shift_q[0];
                bit_idx <= bit_idx + 1'b1;
                cnt     <= bit_cnt_t'(CLKS_PER_BIT - 1);
            end
        end else if (tx_busy_o) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start_i) begin
            shift_q <= {1'b1, tx_byte_i};
        end else if (bit_end) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    a_no_start_busy : assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_start_i |-> !tx_busy_o);

endmodule

`default_nettype wire

// File: src/debug_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module debug_monitor import debug_monitor_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    input  logic rx_i,
    output logic tx_o,
    output logic cpu_clk_o,
    output logic cpu_rst_n_o
);

    logic  rx_valid;
    byte_t rx_byte;
    logic  cmd_accept;
    logic  clk_rise;
    logic  clk_fall;
    logic  rst_toggle;
    logic  sel_manual;
    logic  sel_run;
    logic  hold_start;
    logic  hold_done;
    logic  reply_start;
    logic  reply_done;
    logic  tx_start;
    byte_t tx_byte;
    logic  tx_busy;

    // --------------------------------------------------
    // input side
    // --------------------------------------------------
    uart_rx u_uart_rx (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rx_i       (rx_i),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte)
    );

    // --------------------------------------------------
    // command handling and cpu control
    // --------------------------------------------------
    cmd_sequencer u_cmd_sequencer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .rx_valid_i    (rx_valid),
        .rx_byte_i     (rx_byte),
        .hold_done_i   (hold_done),
        .reply_done_i  (reply_done),
        .cmd_accept_o  (cmd_accept),
        .clk_rise_o    (clk_rise),
        .clk_fall_o    (clk_fall),
        .rst_toggle_o  (rst_toggle),
        .sel_manual_o  (sel_manual),
        .sel_run_o     (sel_run),
        .hold_start_o  (hold_start),
        .reply_start_o (reply_start)
    );

    cpu_clock_ctrl u_cpu_clock_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .clk_rise_i   (clk_rise),
        .clk_fall_i   (clk_fall),
        .rst_toggle_i (rst_toggle),
        .sel_manual_i (sel_manual),
        .sel_run_i    (sel_run),
        .hold_start_i (hold_start),
        .hold_done_o  (hold_done),
        .cpu_clk_o    (cpu_clk_o),
        .cpu_rst_n_o  (cpu_rst_n_o)
    );

    // --------------------------------------------------
    // output side
    // --------------------------------------------------
    reply_sender u_reply_sender (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cmd_accept_i  (cmd_accept),
        .rx_byte_i     (rx_byte),
        .reply_start_i (reply_start),
        .tx_busy_i     (tx_busy),
        .tx_start_o    (tx_start),
        .tx_byte_o     (tx_byte),
        .reply_done_o  (reply_done)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_o       (tx_o),
        .tx_busy_o  (tx_busy)
    );

endmodule

`default_nettype wire

// File: tests/tb_debug_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_monitor import debug_monitor_pkg::*; ();

    localparam int RESET_CYCLES    = 16;
    localparam int RELEASE_TIMEOUT = 40;     // cycles from reset release to cpu release
    localparam int REPLY_TIMEOUT   = 2000;
    localparam int SETTLE_CYCLES   = 200;
    localparam int WATCH_CYCLES    = 4096;   // 2^12
    localparam int ROWS            = 11;

    localparam byte_t LO = 8'h00;
    localparam byte_t HI = 8'h01;
    localparam byte_t DC = 8'hFF;            // level not checked

    localparam byte_t POST_NONE  = 8'd0;
    localparam byte_t POST_RESET = 8'd1;     // reset hold behavior of r
    localparam byte_t POST_RUN   = 8'd2;     // free running clock after k
    localparam byte_t POST_STOP  = 8'd3;     // manual clock parked low
    localparam byte_t POST_PULSE = 8'd4;     // one-cycle manual clock pulse of c

    localparam byte_t ASCII_CR = 8'h0D;
    localparam byte_t ASCII_LF = 8'h0A;

    logic clk;
    logic rst_n_i;
    logic rx_i;
    logic tx_o;
    logic cpu_clk_o;
    logic cpu_rst_n_o;

    // command, letter pair, cpu_clk_o, cpu_rst_n_o, extra check
    logic [47:0] cmd_table [ROWS];

    byte_t tx_bytes [$];                     // decoded reply bytes
    int    checks       = 0;
    int    errors       = 0;
    int    frame_errors = 0;
    int    timeouts     = 0;

    // observer state
    logic  rst_low_seen        = 1'b0;
    logic  first_start_rst_low = 1'b0;
    logic  clk_prev            = 1'b0;
    int    rst_toggles         = 0;
    int    clk_changes         = 0;
    logic  dec_busy            = 1'b0;
    int    dec_idx             = 0;
    int    bit_no              = 0;
    byte_t dec_shift           = '0;

    debug_monitor uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rx_i        (rx_i),
        .tx_o        (tx_o),
        .cpu_clk_o   (cpu_clk_o),
        .cpu_rst_n_o (cpu_rst_n_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // --------------------------------------------------
    // observer, runs on the falling edge
    // --------------------------------------------------
    always @(negedge clk) begin
        if (cpu_rst_n_o === 1'b0) begin
            rst_low_seen = 1'b1;
            if (cpu_clk_o !== clk_prev) begin
                rst_toggles++;
            end
        end
        if (cpu_clk_o !== clk_prev) begin
            clk_changes++;
        end
        clk_prev = cpu_clk_o;

        // dec_idx counts falling edges from the detected start bit
        if (!dec_busy) begin
            if (tx_o === 1'b0) begin
                dec_busy = 1'b1;
                dec_idx  = 0;
                if (tx_bytes.size() == 0) begin
                    first_start_rst_low = rst_low_seen;
                end
            end
        end else begin
            dec_idx++;
            if (dec_idx % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                bit_no = dec_idx / CLKS_PER_BIT;
                if (bit_no == 0) begin
                    if (tx_o !== 1'b0) begin
                        $display("framing error at %0t: start bit on tx_o did not hold", $time);
                        frame_errors++;
                        dec_busy = 1'b0;
                    end
                end else if (bit_no <= 8) begin
                    dec_shift[bit_no-1] = tx_o;     // lsb first
                end else begin
                    if (tx_o !== 1'b1) begin
                        $display("framing error at %0t: stop bit on tx_o is not high", $time);
                        frame_errors++;
                    end else begin
                        tx_bytes.push_back(dec_shift);
                    end
                    dec_busy = 1'b0;
                end
            end
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        errors++;
    endtask

    task automatic load_table();
        cmd_table[0]  = {"z", "Cr", HI, HI, POST_NONE};
        cmd_table[1]  = {"x", "Cf", LO, HI, POST_NONE};
        cmd_table[2]  = {"c", "Ct", LO, HI, POST_PULSE};
        cmd_table[3]  = {"e", "Ra", DC, LO, POST_NONE};
        cmd_table[4]  = {"e", "Ra", DC, HI, POST_NONE};
        cmd_table[5]  = {"q", "Ok", LO, HI, POST_NONE};   // unknown byte
        cmd_table[6]  = {"r", "Rs", DC, HI, POST_RESET};
        cmd_table[7]  = {"j", "Kk", DC, HI, POST_NONE};
        cmd_table[8]  = {"k", "Kk", DC, HI, POST_RUN};
        cmd_table[9]  = {"j", "Kk", DC, HI, POST_NONE};
        cmd_table[10] = {"x", "Cf", LO, HI, POST_STOP};
    endtask

    // observers only write on the falling edge
    task automatic clear_observations();
        @(posedge clk);
        tx_bytes.delete();
        rst_low_seen        = 1'b0;
        first_start_rst_low = 1'b0;
        rst_toggles         = 0;
        clk_changes         = 0;
    endtask

    task automatic send_byte(input byte_t b);
        int i;
        @(negedge clk);
        rx_i = 1'b0;                         // start bit
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rx_i = b[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx_i = 1'b1;                         // stop bit
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic wait_reply(input byte_t cmd);
        int n;
        n = 0;
        while (tx_bytes.size() < 4 && n < REPLY_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (tx_bytes.size() < 4) begin
            $display("timeout: no full reply to command '%c' within %0d cycles",
                     cmd, REPLY_TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic check_reply(input byte_t cmd, input byte_t c0, input byte_t c1);
        byte_t exp_bytes [4];
        int k;
        exp_bytes[0] = c0;
        exp_bytes[1] = c1;
        exp_bytes[2] = ASCII_CR;
        exp_bytes[3] = ASCII_LF;
        checks++;
        if (tx_bytes.size() != 4) begin
            report_mismatch($sformatf("reply length for '%c'", cmd), tx_bytes.size(), 4);
        end
        for (k = 0; k < 4 && k < tx_bytes.size(); k++) begin
            checks++;
            if (tx_bytes[k] !== exp_bytes[k]) begin
                report_mismatch($sformatf("reply to '%c', byte %0d", cmd, k),
                                tx_bytes[k], exp_bytes[k]);
            end
        end
    endtask

    task automatic check_clock_runs();
        int changes;
        logic last;
        changes = 0;
        last    = cpu_clk_o;
        repeat (WATCH_CYCLES) begin
            @(negedge clk);
            if (cpu_clk_o !== last) begin
                changes++;
            end
            last = cpu_clk_o;
        end
        checks++;
        if (changes < 2) begin
            report_mismatch("cpu_clk_o level changes in run mode (minimum)", changes, 2);
        end
    endtask

    task automatic check_clock_stays_low();
        int highs;
        highs = 0;
        repeat (WATCH_CYCLES) begin
            @(negedge clk);
            if (cpu_clk_o !== 1'b0) begin
                highs++;
            end
        end
        checks++;
        if (highs != 0) begin
            report_mismatch("cycles with cpu_clk_o not low after j and x", highs, 0);
        end
    endtask

    // second byte lands while the first reply is on the line
    task automatic check_dropped_byte();
        clear_observations();
        send_byte("z");
        send_byte("x");
        wait_reply("z");
        repeat (2 * SETTLE_CYCLES) @(negedge clk);
        check_reply("z", "C", "r");
        checks++;
        if (cpu_clk_o !== 1'b1) begin
            report_mismatch("cpu_clk_o after dropped x", cpu_clk_o, 1);
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin : main_flow
        int    row;
        int    n;
        byte_t cmd;
        byte_t c0;
        byte_t c1;
        byte_t exp_clk;
        byte_t exp_rst;
        byte_t post;

        rst_n_i = 1'b0;
        rx_i    = 1'b1;
        load_table();

        repeat (RESET_CYCLES) @(negedge clk);
        checks += 2;
        if (tx_o !== 1'b1) report_mismatch("tx_o in reset", tx_o, 1);
        if (cpu_clk_o !== 1'b0) report_mismatch("cpu_clk_o in reset", cpu_clk_o, 0);
        rst_n_i = 1'b1;

        // power-up hold, silent
        n = 0;
        while (cpu_rst_n_o !== 1'b1 && n < RELEASE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cpu_rst_n_o !== 1'b1) begin
            $display("timeout: cpu_rst_n_o still low %0d cycles after reset", RELEASE_TIMEOUT);
            timeouts++;
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
        checks += 2;
        if (tx_bytes.size() != 0) report_mismatch("bytes after power-up", tx_bytes.size(), 0);
        if (tx_o !== 1'b1) report_mismatch("tx_o idle after power-up", tx_o, 1);

        for (row = 0; row < ROWS; row++) begin
            {cmd, c0, c1, exp_clk, exp_rst, post} = cmd_table[row];
            clear_observations();
            send_byte(cmd);
            wait_reply(cmd);
            repeat (SETTLE_CYCLES) @(negedge clk);
            check_reply(cmd, c0, c1);

            if (exp_clk != DC) begin
                checks++;
                if (cpu_clk_o !== exp_clk[0]) begin
                    report_mismatch($sformatf("cpu_clk_o after '%c'", cmd), cpu_clk_o, exp_clk);
                end
            end
            if (exp_rst != DC) begin
                checks++;
                if (cpu_rst_n_o !== exp_rst[0]) begin
                    report_mismatch($sformatf("cpu_rst_n_o after '%c'", cmd),
                                    cpu_rst_n_o, exp_rst);
                end
            end

            if (post == POST_RESET) begin
                checks += 2;
                if (first_start_rst_low !== 1'b1) begin
                    report_mismatch("cpu reset low before first reply byte",
                                    first_start_rst_low, 1);
                end
                // one toggle per held cycle
                if (rst_toggles != RESET_HOLD_CYCLES + 1) begin
                    report_mismatch("cpu_clk_o toggles while reset held",
                                    rst_toggles, RESET_HOLD_CYCLES + 1);
                end
            end else if (post == POST_PULSE) begin
                // rise then fall from a low level
                checks++;
                if (clk_changes != 2) begin
                    report_mismatch("cpu_clk_o level changes for the c pulse",
                                    clk_changes, 2);
                end
            end else if (post == POST_RUN) begin
                check_clock_runs();
            end else if (post == POST_STOP) begin
                check_clock_stays_low();
            end
        end

        check_dropped_byte();

        $display("checks: %0d, value errors: %0d, framing errors: %0d, timeouts: %0d",
                 checks, errors, frame_errors, timeouts);
        if (errors == 0 && frame_errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/debug_monitor_pkg.sv
src/uart_rx.sv
src/cmd_sequencer.sv
src/cpu_clock_ctrl.sv
src/reply_sender.sv
src/uart_tx.sv
src/debug_monitor.sv
tests/tb_debug_monitor.sv

// File: Bender.yml
package:
  name: debug_monitor

sources:
  - src/debug_monitor_pkg.sv
  - src/uart_rx.sv
  - src/cmd_sequencer.sv
  - src/cpu_clock_ctrl.sv
  - src/reply_sender.sv
  - src/uart_tx.sv
  - src/debug_monitor.sv

  - target: test
    files:
      - tests/tb_debug_monitor.sv
